//--- prf_pkg.sv
// sizes and types shared by the banked physical register file
// imported by wildcard into every register file module that needs them
`default_nettype none

package prf_pkg;

    // ------------------------------
    // register file geometry
    // ------------------------------
    localparam int PRF_DATA_WIDTH = 32;
    localparam int PR_COUNT = 64;
    localparam int LOG_PR_COUNT = $clog2(PR_COUNT);

    // bank select is the low bits of a register number
    localparam int PRF_BANK_COUNT = 4;
    localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);
    localparam int UPPER_PR_WIDTH = LOG_PR_COUNT - LOG_PRF_BANK_COUNT;
    localparam int BANK_DEPTH = PR_COUNT / PRF_BANK_COUNT;

    // ------------------------------
    // requesters
    // ------------------------------
    localparam int PRF_RR_COUNT = 4;
    localparam int PRF_WR_COUNT = 2;

    // ------------------------------
    // types
    // ------------------------------

    // full physical register number
    typedef logic [LOG_PR_COUNT-1:0] pr_t;

    // index inside one bank
    typedef logic [UPPER_PR_WIDTH-1:0] upper_pr_t;

    // register value
    typedef logic [PRF_DATA_WIDTH-1:0] prf_data_t;

endpackage

`default_nettype wire

//--- prf_priority_pick.sv
// one-hot pick among requesters, highest index first
// requests inside the mask are preferred so the arbiter rotates fairly
// used per bank by both the read and the writeback arbiter
`timescale 1ns/1ps
`default_nettype none

module prf_priority_pick #(
    parameter int REQ_COUNT = 4
) (
    input  wire [REQ_COUNT-1:0] req,
    input  wire [REQ_COUNT-1:0] mask,
    output logic [REQ_COUNT-1:0] grant
);

    logic [REQ_COUNT-1:0] masked_req;
    logic [REQ_COUNT-1:0] pool;

    assign masked_req = req & mask;

    // fall back to all requests when none sit below the last winner
    assign pool = (|masked_req) ? masked_req : req;

    // walk upward so the highest set bit has the last word
    always_comb begin
        grant = '0;
        for (int i = 0; i < REQ_COUNT; i++) begin
            if (pool[i]) begin
                grant = '0;
                grant[i] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- prf_bank_ram.sv
// storage for one register file bank
// two combinational read ports fed by registered indices, one clocked write port
`timescale 1ns/1ps
`default_nettype none

module prf_bank_ram import prf_pkg::*; (
    input  wire              CLK,

    // read ports
    input  wire upper_pr_t   rd_index0,
    output prf_data_t        rd_data0,
    input  wire upper_pr_t   rd_index1,
    output prf_data_t        rd_data1,

    // write port
    input  wire              wr_en,
    input  wire upper_pr_t   wr_index,
    input  wire prf_data_t   wr_data
);

    prf_data_t mem [BANK_DEPTH];

    assign rd_data0 = mem[rd_index0];
    assign rd_data1 = mem[rd_index1];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_index] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- prf_read_arbiter.sv
// read request arbitration for the banked register file
// grants up to two reads per bank per cycle and holds the losers for retry
// acks, port bits and bank read indices come out registered
`timescale 1ns/1ps
`default_nettype none

module prf_read_arbiter import prf_pkg::*; (
    input  wire                               CLK,
    input  wire                               nRST,

    // requests by read requester
    input  wire [PRF_RR_COUNT-1:0]            reg_read_req_valid,
    input  wire pr_t [PRF_RR_COUNT-1:0]       reg_read_req_pr,

    // ack and granted port by read requester
    output logic [PRF_RR_COUNT-1:0]           reg_read_ack,
    output logic [PRF_RR_COUNT-1:0]           reg_read_port,

    // bank read indices
    output upper_pr_t [PRF_BANK_COUNT-1:0]    rd_index0,
    output upper_pr_t [PRF_BANK_COUNT-1:0]    rd_index1
);

    // held requests
    logic [PRF_RR_COUNT-1:0]                      pend_valid;
    pr_t [PRF_RR_COUNT-1:0]                       pend_pr;

    // new and held requests merged
    logic [PRF_RR_COUNT-1:0]                      req_valid;
    pr_t [PRF_RR_COUNT-1:0]                       req_pr;

    logic [PRF_BANK_COUNT-1:0][PRF_RR_COUNT-1:0]  bank_req;
    logic [PRF_BANK_COUNT-1:0][PRF_RR_COUNT-1:0]  bank_req1;
    logic [PRF_BANK_COUNT-1:0][PRF_RR_COUNT-1:0]  p0_grant;
    logic [PRF_BANK_COUNT-1:0][PRF_RR_COUNT-1:0]  p1_grant;
    logic [PRF_BANK_COUNT-1:0][PRF_RR_COUNT-1:0]  last_mask;
    logic [PRF_BANK_COUNT-1:0][PRF_RR_COUNT-1:0]  next_mask;

    logic [PRF_RR_COUNT-1:0]                      next_ack;
    logic [PRF_RR_COUNT-1:0]                      next_port;
    upper_pr_t [PRF_BANK_COUNT-1:0]               next_index0;
    upper_pr_t [PRF_BANK_COUNT-1:0]               next_index1;

    // ------------------------------
    // merge and route to banks
    // ------------------------------
    always_comb begin
        req_valid = reg_read_req_valid | pend_valid;
        bank_req = '0;
        for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
            // a held request keeps its own register number
            req_pr[rr] = pend_valid[rr] ? pend_pr[rr] : reg_read_req_pr[rr];
            bank_req[req_pr[rr][LOG_PRF_BANK_COUNT-1:0]][rr] = req_valid[rr];
        end
    end

    // ------------------------------
    // per bank port 0 then port 1
    // ------------------------------
    for (genvar b = 0; b < PRF_BANK_COUNT; b++) begin : g_bank
        // port 1 sees what port 0 left over
        assign bank_req1[b] = bank_req[b] & ~p0_grant[b];

        prf_priority_pick #(
            .REQ_COUNT (PRF_RR_COUNT)
        ) u_pick_port0 (
            .req   (bank_req[b]),
            .mask  (last_mask[b]),
            .grant (p0_grant[b])
        );

        prf_priority_pick #(
            .REQ_COUNT (PRF_RR_COUNT)
        ) u_pick_port1 (
            .req   (bank_req1[b]),
            .mask  (last_mask[b]),
            .grant (p1_grant[b])
        );
    end

    always_comb begin
        next_ack = '0;
        next_port = '0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            next_ack |= p0_grant[b] | p1_grant[b];
            next_port |= p1_grant[b];

            // one-hot mux of the in-bank index per port
            next_index0[b] = '0;
            next_index1[b] = '0;
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                next_index0[b] |= req_pr[rr][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]
                    & {UPPER_PR_WIDTH{p0_grant[b][rr]}};
                next_index1[b] |= req_pr[rr][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]
                    & {UPPER_PR_WIDTH{p1_grant[b][rr]}};
            end

            // everything below the port 1 winner
            next_mask[b] = '0;
            for (int i = PRF_RR_COUNT - 2; i >= 0; i--) begin
                next_mask[b][i] = p1_grant[b][i+1] | next_mask[b][i+1];
            end
        end
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pend_valid <= '0;
            last_mask <= '0;
            reg_read_ack <= '0;
            reg_read_port <= '0;
        end else begin
            pend_valid <= req_valid & ~next_ack;
            last_mask <= next_mask;
            reg_read_ack <= next_ack;
            reg_read_port <= next_port;
        end
    end

    always_ff @(posedge CLK) begin
        pend_pr <= req_pr;
        rd_index0 <= next_index0;
        rd_index1 <= next_index1;
    end

endmodule

`default_nettype wire

//--- prf_writeback_arbiter.sv
// writeback arbitration for the banked register file
// one writeback per bank per cycle goes onto that bank's bus and into its storage
// a writer whose writeback lost is held and shows not-ready until granted
`timescale 1ns/1ps
`default_nettype none

module prf_writeback_arbiter import prf_pkg::*; (
    input  wire                               CLK,
    input  wire                               nRST,

    // writebacks by write requester
    input  wire [PRF_WR_COUNT-1:0]            wb_valid,
    input  wire prf_data_t [PRF_WR_COUNT-1:0] wb_data,
    input  wire pr_t [PRF_WR_COUNT-1:0]       wb_pr,
    output logic [PRF_WR_COUNT-1:0]           wb_ready,

    // writeback bus by bank, also the bank write port
    output logic [PRF_BANK_COUNT-1:0]         wb_bus_valid,
    output prf_data_t [PRF_BANK_COUNT-1:0]    wb_bus_data,
    output upper_pr_t [PRF_BANK_COUNT-1:0]    wb_bus_upper_pr
);

    // held writebacks
    logic [PRF_WR_COUNT-1:0]                      pend_valid;
    prf_data_t [PRF_WR_COUNT-1:0]                 pend_data;
    pr_t [PRF_WR_COUNT-1:0]                       pend_pr;

    // offered this cycle, held one first
    logic [PRF_WR_COUNT-1:0]                      req_valid;
    prf_data_t [PRF_WR_COUNT-1:0]                 req_data;
    pr_t [PRF_WR_COUNT-1:0]                       req_pr;

    logic [PRF_BANK_COUNT-1:0][PRF_WR_COUNT-1:0]  bank_req;
    logic [PRF_BANK_COUNT-1:0][PRF_WR_COUNT-1:0]  grant;
    logic [PRF_BANK_COUNT-1:0][PRF_WR_COUNT-1:0]  last_mask;
    logic [PRF_BANK_COUNT-1:0][PRF_WR_COUNT-1:0]  next_mask;
    logic [PRF_WR_COUNT-1:0]                      granted;

    logic [PRF_BANK_COUNT-1:0]                    next_bus_valid;
    prf_data_t [PRF_BANK_COUNT-1:0]               next_bus_data;
    upper_pr_t [PRF_BANK_COUNT-1:0]               next_bus_upper_pr;

    assign wb_ready = ~pend_valid;

    // ------------------------------
    // merge and route to banks
    // ------------------------------
    always_comb begin
        // new input is ignored while a writeback is held
        req_valid = pend_valid | wb_valid;
        bank_req = '0;
        for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
            req_data[wr] = pend_valid[wr] ? pend_data[wr] : wb_data[wr];
            req_pr[wr] = pend_valid[wr] ? pend_pr[wr] : wb_pr[wr];
            bank_req[req_pr[wr][LOG_PRF_BANK_COUNT-1:0]][wr] = req_valid[wr];
        end
    end

    for (genvar b = 0; b < PRF_BANK_COUNT; b++) begin : g_bank
        prf_priority_pick #(
            .REQ_COUNT (PRF_WR_COUNT)
        ) u_pick (
            .req   (bank_req[b]),
            .mask  (last_mask[b]),
            .grant (grant[b])
        );
    end

    // ------------------------------
    // bus select and next mask
    // ------------------------------
    always_comb begin
        granted = '0;
        for (int b = 0; b < PRF_BANK_COUNT; b++) begin
            granted |= grant[b];
            next_bus_valid[b] = |grant[b];
            next_bus_data[b] = '0;
            next_bus_upper_pr[b] = '0;
            for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                next_bus_data[b] |= req_data[wr] & {PRF_DATA_WIDTH{grant[b][wr]}};
                next_bus_upper_pr[b] |= req_pr[wr][LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]
                    & {UPPER_PR_WIDTH{grant[b][wr]}};
            end

            next_mask[b] = '0;
            for (int i = PRF_WR_COUNT - 2; i >= 0; i--) begin
                next_mask[b][i] = grant[b][i+1] | next_mask[b][i+1];
            end
        end

        // register 0 is accepted but never written or broadcast
        if (next_bus_upper_pr[0] == '0) begin
            next_bus_valid[0] = 1'b0;
        end
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            pend_valid <= '0;
            last_mask <= '0;
            wb_bus_valid <= '0;
        end else begin
            pend_valid <= req_valid & ~granted;
            last_mask <= next_mask;
            wb_bus_valid <= next_bus_valid;
        end
    end

    always_ff @(posedge CLK) begin
        pend_data <= req_data;
        pend_pr <= req_pr;
        wb_bus_data <= next_bus_data;
        wb_bus_upper_pr <= next_bus_upper_pr;
    end

endmodule

`default_nettype wire

//--- prf_top.sv
// top level of the banked physical register file
// joins the read and writeback arbiters to one storage block per bank
`timescale 1ns/1ps
`default_nettype none

module prf_top import prf_pkg::*; (
    input  wire                                    CLK,
    input  wire                                    nRST,

    // read requests and acks by read requester
    input  wire [PRF_RR_COUNT-1:0]                 reg_read_req_valid,
    input  wire pr_t [PRF_RR_COUNT-1:0]            reg_read_req_pr,
    output logic [PRF_RR_COUNT-1:0]                reg_read_ack,
    output logic [PRF_RR_COUNT-1:0]                reg_read_port,

    // read data by bank and port
    output prf_data_t [PRF_BANK_COUNT-1:0][1:0]    reg_read_data,

    // writebacks by write requester
    input  wire [PRF_WR_COUNT-1:0]                 wb_valid,
    input  wire prf_data_t [PRF_WR_COUNT-1:0]      wb_data,
    input  wire pr_t [PRF_WR_COUNT-1:0]            wb_pr,
    output logic [PRF_WR_COUNT-1:0]                wb_ready,

    // writeback bus by bank
    output logic [PRF_BANK_COUNT-1:0]              wb_bus_valid,
    output prf_data_t [PRF_BANK_COUNT-1:0]         wb_bus_data,
    output upper_pr_t [PRF_BANK_COUNT-1:0]         wb_bus_upper_pr
);

    upper_pr_t [PRF_BANK_COUNT-1:0] rd_index0;
    upper_pr_t [PRF_BANK_COUNT-1:0] rd_index1;

    prf_read_arbiter u_read_arbiter (
        .CLK                (CLK),
        .nRST               (nRST),
        .reg_read_req_valid (reg_read_req_valid),
        .reg_read_req_pr    (reg_read_req_pr),
        .reg_read_ack       (reg_read_ack),
        .reg_read_port      (reg_read_port),
        .rd_index0          (rd_index0),
        .rd_index1          (rd_index1)
    );

    prf_writeback_arbiter u_writeback_arbiter (
        .CLK             (CLK),
        .nRST            (nRST),
        .wb_valid        (wb_valid),
        .wb_data         (wb_data),
        .wb_pr           (wb_pr),
        .wb_ready        (wb_ready),
        .wb_bus_valid    (wb_bus_valid),
        .wb_bus_data     (wb_bus_data),
        .wb_bus_upper_pr (wb_bus_upper_pr)
    );

    // bus values double as the bank write port
    for (genvar b = 0; b < PRF_BANK_COUNT; b++) begin : g_bank
        prf_bank_ram u_bank_ram (
            .CLK       (CLK),
            .rd_index0 (rd_index0[b]),
            .rd_data0  (reg_read_data[b][0]),
            .rd_index1 (rd_index1[b]),
            .rd_data1  (reg_read_data[b][1]),
            .wr_en     (wb_bus_valid[b]),
            .wr_index  (wb_bus_upper_pr[b]),
            .wr_data   (wb_bus_data[b])
        );
    end

endmodule

`default_nettype wire

//--- tb_prf_model.svh
// reference model for the banked register file testbench
// arbitration picks and expected register contents, included inside tb_prf
`ifndef TB_PRF_MODEL_SVH
`define TB_PRF_MODEL_SVH

// expected contents, written one edge after a value shows on its bank's bus
prf_data_t model_regs [PR_COUNT];

// highest requester wins, the ones below the last winner go first
function automatic logic [3:0] pick_grant(input logic [3:0] req, input logic [3:0] mask);
    logic [3:0] pool;
    pool = ((req & mask) != 4'b0000) ? (req & mask) : req;
    for (int i = 3; i >= 0; i--) begin
        if (pool[i]) begin
            return 4'b0001 << i;
        end
    end
    return 4'b0000;
endfunction

// all requester positions below the winner, empty without a winner
function automatic logic [3:0] mask_below(input logic [3:0] grant);
    for (int i = 3; i >= 0; i--) begin
        if (grant[i]) begin
            return (4'b0001 << i) - 4'b0001;
        end
    end
    return 4'b0000;
endfunction

// port 1 grant in the upper half, zero for the single writeback port
function automatic logic [7:0] bank_grants(input logic [3:0] req, input logic [3:0] mask,
                                           input bit two_ports);
    logic [3:0] g0;
    logic [3:0] g1;
    g0 = pick_grant(req, mask);
    g1 = two_ports ? pick_grant(req & ~g0, mask) : 4'b0000;
    return {g1, g0};
endfunction

`endif

//--- tb_prf.sv
// testbench for the banked physical register file
// a cycle model predicts acks, read data and writeback bus values,
// a negedge process compares them with the DUT, and directed tests add timing checks
`timescale 1ns/1ps
`default_nettype none

module tb_prf import prf_pkg::*; ();

    localparam int SEED = 32'h5b6cedf5;
    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY = 1;
    localparam int WAIT_LIMIT = 50;
    localparam int RANDOM_OPS = 40;

    logic CLK;
    logic nRST;
    logic [PRF_RR_COUNT-1:0] reg_read_req_valid;
    pr_t [PRF_RR_COUNT-1:0] reg_read_req_pr;
    logic [PRF_RR_COUNT-1:0] reg_read_ack;
    logic [PRF_RR_COUNT-1:0] reg_read_port;
    prf_data_t [PRF_BANK_COUNT-1:0][1:0] reg_read_data;
    logic [PRF_WR_COUNT-1:0] wb_valid;
    prf_data_t [PRF_WR_COUNT-1:0] wb_data;
    pr_t [PRF_WR_COUNT-1:0] wb_pr;
    logic [PRF_WR_COUNT-1:0] wb_ready;
    logic [PRF_BANK_COUNT-1:0] wb_bus_valid;
    prf_data_t [PRF_BANK_COUNT-1:0] wb_bus_data;
    upper_pr_t [PRF_BANK_COUNT-1:0] wb_bus_upper_pr;

    // model state and expected outputs
    logic [PRF_RR_COUNT-1:0] m_rd_pend;
    pr_t m_rd_pr [PRF_RR_COUNT];
    logic [3:0] m_rd_mask [PRF_BANK_COUNT];
    logic [PRF_WR_COUNT-1:0] m_wb_pend;
    pr_t m_wb_pr [PRF_WR_COUNT];
    prf_data_t m_wb_data [PRF_WR_COUNT];
    logic [3:0] m_wb_mask [PRF_BANK_COUNT];
    logic [PRF_RR_COUNT-1:0] exp_ack;
    logic [PRF_RR_COUNT-1:0] exp_port;
    prf_data_t exp_rdata [PRF_RR_COUNT];
    logic [PRF_WR_COUNT-1:0] exp_ready;
    logic [PRF_BANK_COUNT-1:0] exp_bus_valid;
    prf_data_t exp_bus_data [PRF_BANK_COUNT];
    upper_pr_t exp_bus_idx [PRF_BANK_COUNT];

    int compare_fails;
    int test_fails;
    int tests_run;
    int tests_failed;
    int fails_at_start;

    `include "tb_prf_model.svh"

    prf_top UUT (
        .CLK                (CLK),
        .nRST               (nRST),
        .reg_read_req_valid (reg_read_req_valid),
        .reg_read_req_pr    (reg_read_req_pr),
        .reg_read_ack       (reg_read_ack),
        .reg_read_port      (reg_read_port),
        .reg_read_data      (reg_read_data),
        .wb_valid           (wb_valid),
        .wb_data            (wb_data),
        .wb_pr              (wb_pr),
        .wb_ready           (wb_ready),
        .wb_bus_valid       (wb_bus_valid),
        .wb_bus_data        (wb_bus_data),
        .wb_bus_upper_pr    (wb_bus_upper_pr)
    );

    always #HALF_PERIOD CLK = ~CLK;

    // ------------------------------
    // reference model, one step per edge
    // ------------------------------
    always @(posedge CLK or negedge nRST) begin : reference_step
        logic [PRF_RR_COUNT-1:0] rd_valid;
        logic [PRF_WR_COUNT-1:0] wr_valid;
        logic [PRF_WR_COUNT-1:0] granted;
        logic [3:0] req;
        logic [7:0] g;
        if (!nRST) begin
            m_rd_pend = '0;
            m_wb_pend = '0;
            exp_ack = '0;
            exp_port = '0;
            exp_ready = '1;
            exp_bus_valid = '0;
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                m_rd_mask[b] = 4'b0000;
                m_wb_mask[b] = 4'b0000;
            end
        end else begin
            // last cycle's bus lands in storage at this edge
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                if (exp_bus_valid[b]) begin
                    model_regs[{exp_bus_idx[b], 2'(b)}] = exp_bus_data[b];
                end
            end

            rd_valid = reg_read_req_valid | m_rd_pend;
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                if (!m_rd_pend[rr]) begin
                    m_rd_pr[rr] = reg_read_req_pr[rr];
                end
            end
            exp_ack = '0;
            exp_port = '0;
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                req = 4'b0000;
                for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                    req[rr] = rd_valid[rr] && (m_rd_pr[rr][1:0] == 2'(b));
                end
                g = bank_grants(req, m_rd_mask[b], 1'b1);
                m_rd_mask[b] = mask_below(g[7:4]);
                exp_ack |= g[3:0] | g[7:4];
                exp_port |= g[7:4];
            end
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                if (exp_ack[rr]) begin
                    exp_rdata[rr] = model_regs[m_rd_pr[rr]];
                end
            end
            m_rd_pend = rd_valid & ~exp_ack;

            // a held writeback hides the writer's new input
            wr_valid = wb_valid | m_wb_pend;
            for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                if (!m_wb_pend[wr]) begin
                    m_wb_pr[wr] = wb_pr[wr];
                    m_wb_data[wr] = wb_data[wr];
                end
            end
            granted = '0;
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                req = 4'b0000;
                for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                    req[wr] = wr_valid[wr] && (m_wb_pr[wr][1:0] == 2'(b));
                end
                g = bank_grants(req, m_wb_mask[b], 1'b0);
                m_wb_mask[b] = mask_below(g[3:0]);
                exp_bus_valid[b] = 1'b0;
                for (int wr = 0; wr < PRF_WR_COUNT; wr++) begin
                    if (g[wr]) begin
                        granted[wr] = 1'b1;
                        exp_bus_data[b] = m_wb_data[wr];
                        exp_bus_idx[b] = m_wb_pr[wr][5:2];
                        // register 0 is accepted but stays off the bus
                        exp_bus_valid[b] = (m_wb_pr[wr] != 6'd0);
                    end
                end
            end
            m_wb_pend = wr_valid & ~granted;
            exp_ready = ~m_wb_pend;
        end
    end

    function automatic bit value_ok(input string name, input logic [63:0] got,
                                    input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR time %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
        return got === exp;
    endfunction

    // ------------------------------
    // compare, mid-cycle where outputs are stable
    // ------------------------------
    always @(negedge CLK) begin : compare_outputs
        bit ok;
        if (nRST) begin
            ok = value_ok("reg_read_ack", 64'(reg_read_ack), 64'(exp_ack));
            ok &= value_ok("reg_read_port", 64'(reg_read_port), 64'(exp_port));
            ok &= value_ok("wb_ready", 64'(wb_ready), 64'(exp_ready));
            ok &= value_ok("wb_bus_valid", 64'(wb_bus_valid), 64'(exp_bus_valid));
            for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
                if (exp_ack[rr]) begin
                    ok &= value_ok($sformatf("reg_read_data for reader %0d", rr),
                        64'(reg_read_data[m_rd_pr[rr][1:0]][exp_port[rr]]),
                        64'(exp_rdata[rr]));
                end
            end
            for (int b = 0; b < PRF_BANK_COUNT; b++) begin
                if (exp_bus_valid[b]) begin
                    ok &= value_ok($sformatf("wb_bus_data[%0d]", b),
                        64'(wb_bus_data[b]), 64'(exp_bus_data[b]));
                    ok &= value_ok($sformatf("wb_bus_upper_pr[%0d]", b),
                        64'(wb_bus_upper_pr[b]), 64'(exp_bus_idx[b]));
                end
            end
            if (!ok) begin
                compare_fails++;
            end
        end
    end

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    task automatic direct_check(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        if (!value_ok(name, got, exp)) begin
            test_fails++;
        end
    endtask

    task automatic report_and_finish();
        int fails;
        fails = compare_fails + test_fails;
        $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, fails);
        if (fails == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        test_fails++;
        report_and_finish();
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #DRIVE_DELAY;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic begin_test();
        tests_run++;
        fails_at_start = compare_fails + test_fails;
    endtask

    task automatic end_test(input string name);
        bit failed;
        failed = (compare_fails + test_fails) != fails_at_start;
        if (failed) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, failed ? "FAILED" : "ok");
    endtask

    // offer once ready, hold valid for one cycle
    task automatic write_one(input int wr, input pr_t pr, input prf_data_t data);
        int waited;
        waited = 0;
        while (!wb_ready[wr]) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("writer %0d never became ready", wr));
            end
            next_cycle();
            waited++;
        end
        wb_valid[wr] = 1'b1;
        wb_pr[wr] = pr;
        wb_data[wr] = data;
        next_cycle();
        wb_valid[wr] = 1'b0;
    endtask

    // one-cycle request, then wait for the ack
    task automatic read_one(input int rr, input pr_t pr, output int latency);
        reg_read_req_valid[rr] = 1'b1;
        reg_read_req_pr[rr] = pr;
        next_cycle();
        reg_read_req_valid[rr] = 1'b0;
        latency = 1;
        while (!reg_read_ack[rr]) begin
            if (latency == WAIT_LIMIT) begin
                abort_run($sformatf("reader %0d got no ack for register %0d", rr, pr));
            end
            next_cycle();
            latency++;
        end
    endtask

    task automatic reader_traffic(input int rr);
        int latency;
        repeat (RANDOM_OPS) begin
            idle($urandom % 3);
            read_one(rr, 6'(1 + $urandom % 63), latency);
        end
    endtask

    task automatic writer_traffic(input int wr);
        repeat (RANDOM_OPS) begin
            idle($urandom % 3);
            write_one(wr, 6'(1 + $urandom % 63), $urandom);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    initial begin : run_tests
        int latency;
        prf_data_t data;
        logic [1:0] bank;
        void'($urandom(SEED));
        CLK = 1'b0;
        nRST = 1'b0;
        reg_read_req_valid = '0;
        reg_read_req_pr = '0;
        wb_valid = '0;
        wb_pr = '0;
        wb_data = '0;
        tests_run = 0;
        tests_failed = 0;
        test_fails = 0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #DRIVE_DELAY;
        nRST = 1'b1;

        begin_test();
        direct_check("reg_read_ack", 64'(reg_read_ack), 64'd0);
        direct_check("wb_bus_valid", 64'(wb_bus_valid), 64'd0);
        direct_check("wb_ready", 64'(wb_ready), 64'b11);
        end_test("reset state");

        // fill every nonzero register, then read each back uncontended
        begin_test();
        for (int pr = 1; pr < PR_COUNT; pr++) begin
            data = ($urandom & 32'hffff_ff00) | 32'(pr);
            bank = 2'(pr);
            write_one(pr % 2, 6'(pr), data);
            direct_check("wb_bus_valid", 64'(wb_bus_valid[bank]), 64'd1);
            direct_check("wb_bus_data", 64'(wb_bus_data[bank]), 64'(data));
            direct_check("wb_bus_upper_pr", 64'(wb_bus_upper_pr[bank]), 64'(pr / 4));
        end
        idle(2);
        for (int pr = 1; pr < PR_COUNT; pr++) begin
            bank = 2'(pr);
            read_one(pr % 4, 6'(pr), latency);
            direct_check("read latency", 64'(latency), 64'd1);
            direct_check("reg_read_data", 64'(reg_read_data[bank][reg_read_port[pr % 4]]),
                64'(model_regs[pr]));
        end
        end_test("write then read");

        // registers 6 and 10 both sit in bank 2
        idle(3);
        begin_test();
        wb_pr[0] = 6'd6;
        wb_data[0] = 32'hc0de_0006;
        wb_pr[1] = 6'd10;
        wb_data[1] = 32'hc0de_000a;
        wb_valid = 2'b11;
        next_cycle();
        wb_valid = 2'b00;
        direct_check("wb_bus_valid", 64'(wb_bus_valid), 64'b0100);
        direct_check("wb_bus_data[2]", 64'(wb_bus_data[2]), 64'hc0de_000a);
        direct_check("wb_ready", 64'(wb_ready), 64'b10);
        next_cycle();
        direct_check("wb_bus_valid", 64'(wb_bus_valid), 64'b0100);
        direct_check("wb_bus_data[2]", 64'(wb_bus_data[2]), 64'hc0de_0006);
        direct_check("wb_bus_upper_pr[2]", 64'(wb_bus_upper_pr[2]), 64'd1);
        direct_check("wb_ready", 64'(wb_ready), 64'b11);
        end_test("writeback contention");

        // readers ask for registers 1, 5, 9 and 13, all in bank 1
        idle(3);
        begin_test();
        for (int rr = 0; rr < PRF_RR_COUNT; rr++) begin
            reg_read_req_pr[rr] = 6'(4 * rr + 1);
        end
        reg_read_req_valid = '1;
        next_cycle();
        reg_read_req_valid = '0;
        direct_check("reg_read_ack", 64'(reg_read_ack), 64'b1100);
        direct_check("reg_read_port", 64'(reg_read_port), 64'b0100);
        direct_check("reg_read_data[1][0]", 64'(reg_read_data[1][0]), 64'(model_regs[13]));
        direct_check("reg_read_data[1][1]", 64'(reg_read_data[1][1]), 64'(model_regs[9]));
        next_cycle();
        direct_check("reg_read_ack", 64'(reg_read_ack), 64'b0011);
        direct_check("reg_read_port", 64'(reg_read_port), 64'b0001);
        direct_check("reg_read_data[1][0]", 64'(reg_read_data[1][0]), 64'(model_regs[5]));
        direct_check("reg_read_data[1][1]", 64'(reg_read_data[1][1]), 64'(model_regs[1]));
        end_test("read contention and fairness");

        idle(2);
        begin_test();
        write_one(0, 6'd0, 32'hdead_0000);
        repeat (3) begin
            direct_check("wb_bus_valid", 64'(wb_bus_valid), 64'd0);
            direct_check("wb_ready", 64'(wb_ready), 64'b11);
            next_cycle();
        end
        end_test("register 0");

        begin_test();
        fork
            reader_traffic(0);
            reader_traffic(1);
            reader_traffic(2);
            reader_traffic(3);
            writer_traffic(0);
            writer_traffic(1);
        join
        idle(3);
        end_test("random traffic");

        report_and_finish();
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
prf_pkg.sv
prf_priority_pick.sv
prf_bank_ram.sv
prf_read_arbiter.sv
prf_writeback_arbiter.sv
prf_top.sv
tb_prf.sv

//--- run_sim.sh
#!/bin/sh
# build the register file testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_prf -f flist.f -o tb_prf_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_prf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
